/* Bender.yml */
package:
  name: bnn_layer

sources:
  - include_dirs:
      - include
    files:
      - verilog/bnnPkg.sv
      - verilog/coreCtrlIf.sv
      - verilog/WeightStore.sv
      - verilog/BinaryCore.sv
      - verilog/ComputeCoreGroup.sv
      - verilog/ThresholdUnit.sv
      - verilog/LayerSequencer.sv
      - verilog/BnnLayerTop.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - tb/tbClock.sv
      - tb/BnnLayerTb.sv

/* include/bnn_macros.svh */
`ifndef BNN_MACROS_SVH
`define BNN_MACROS_SVH

// Layer geometry
`define BNN_CHANNELS 8
`define BNN_ACT_WIDTH 64

// Popcount of one 64-bit word fits in 7 bits
`define BNN_POP_WIDTH 7

// Weight words per channel, one per word position
`define BNN_WEIGHT_DEPTH 16
`define BNN_ADDR_WIDTH 4

// Sum and threshold width
`define BNN_ACC_WIDTH 12

// Weight read, popcount, accumulate
`define BNN_PIPE_DEPTH 3

`endif

/* list.f */
+incdir+include
verilog/bnnPkg.sv
verilog/coreCtrlIf.sv
verilog/WeightStore.sv
verilog/BinaryCore.sv
verilog/ComputeCoreGroup.sv
verilog/ThresholdUnit.sv
verilog/LayerSequencer.sv
verilog/BnnLayerTop.sv
tb/tbClock.sv
tb/BnnLayerTb.sv

/* tb/BnnLayerTb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "bnn_macros.svh"

module BnnLayerTb;

  localparam int NumRows = 9;
  localparam int Chans = `BNN_CHANNELS;
  localparam int Depth = `BNN_WEIGHT_DEPTH;
  localparam int ResLatency = 4;  // 3 core stages plus the compare register

  typedef enum logic [1:0] {thrRandom, thrBelow, thrEqual, thrAbove} thrModeE;

  typedef struct packed {
    logic [4:0] words;
    logic [3:0] gap;     // Idle cycles between words
    logic [3:0] stall;   // Cycles with resReady low
    thrModeE    mode;
    logic       copyPrev;  // Same words and thresholds as the row before
  } rowT;

  logic clk;
  logic arstN;
  logic actValid;
  logic actReady;
  bnnPkg::actWordT actWord;
  bnnPkg::addrT numWords;
  logic wgtWe;
  bnnPkg::chanT wgtChannel;
  bnnPkg::addrT wgtAddr;
  bnnPkg::actWordT wgtData;
  logic thrWe;
  bnnPkg::chanT thrChannel;
  bnnPkg::accT thrData;
  logic resValid;
  logic resReady;
  bnnPkg::chanVecT resBits;

  rowT rows [NumRows];
  bnnPkg::actWordT weights [Chans][Depth];  // Mirror of the weight store
  bnnPkg::actWordT words [NumRows][Depth];
  bnnPkg::accT thr [NumRows][Chans];
  bnnPkg::accT expSum [NumRows][Chans];
  bnnPkg::chanVecT expBits [NumRows];
  int timeoutLimit = 1000000;
  int cycleCount = 0;
  int unsigned seed;

  tbClock clock_i (.clk(clk));

  BnnLayerTop dut_i (
    .clk       (clk),
    .arstN     (arstN),
    .actValid  (actValid),
    .actReady  (actReady),
    .actWord   (actWord),
    .numWords  (numWords),
    .wgtWe     (wgtWe),
    .wgtChannel(wgtChannel),
    .wgtAddr   (wgtAddr),
    .wgtData   (wgtData),
    .thrWe     (thrWe),
    .thrChannel(thrChannel),
    .thrData   (thrData),
    .resValid  (resValid),
    .resReady  (resReady),
    .resBits   (resBits)
  );

  always @(posedge clk) begin
    cycleCount = cycleCount + 1;
    if (cycleCount > timeoutLimit) begin
      $display("Timeout after %0d cycles, the DUT hung", cycleCount);
      $display("TESTS FAILED");
      $fatal(1);
    end
  end

  task automatic checkBits(input string name, input bnnPkg::chanVecT got, exp);
    if (got !== exp) begin
      $display("FAIL %s got 0x%h expected 0x%h", name, got, exp);
      $display("TESTS FAILED");
      $fatal(1);
    end
  endtask

  task automatic checkSum(input string name, input bnnPkg::accT got, exp);
    if (got !== exp) begin
      $display("FAIL %s got 0x%h expected 0x%h", name, got, exp);
      $display("TESTS FAILED");
      $fatal(1);
    end
  endtask

  task automatic checkFlag(input string name, input logic got, exp);
    if (got !== exp) begin
      $display("FAIL %s got 0x%h expected 0x%h", name, got, exp);
      $display("TESTS FAILED");
      $fatal(1);
    end
  endtask

  task automatic checkLatency(input int got, exp);
    if (got != exp) begin
      $display("FAIL resValid latency got 0x%h expected 0x%h", got, exp);
      $display("TESTS FAILED");
      $fatal(1);
    end
  endtask

  // Matching bit positions between a word and its weight
  function automatic int countMatches(input bnnPkg::actWordT a, w);
    int c;
    c = 0;
    for (int b = 0; b < `BNN_ACT_WIDTH; b++) begin
      if (a[b] == w[b]) c++;
    end
    return c;
  endfunction

  task automatic buildModel();
    int n;
    bnnPkg::accT s;
    for (int ch = 0; ch < Chans; ch++) begin
      for (int a = 0; a < Depth; a++) weights[ch][a] = {$urandom, $urandom};
    end
    for (int r = 0; r < NumRows; r++) begin
      n = rows[r].words;
      for (int i = 0; i < Depth; i++) begin
        words[r][i] = rows[r].copyPrev ? words[r-1][i] : {$urandom, $urandom};
      end
      for (int ch = 0; ch < Chans; ch++) begin
        s = '0;
        for (int i = 0; i < n; i++) begin
          s = s + bnnPkg::accT'(countMatches(words[r][i], weights[ch][i]));
        end
        expSum[r][ch] = s;
        if (rows[r].copyPrev) thr[r][ch] = thr[r-1][ch];
        else begin
          case (rows[r].mode)
            thrBelow: thr[r][ch] = s - 1'b1;
            thrEqual: thr[r][ch] = s;
            thrAbove: thr[r][ch] = s + 1'b1;
            default:  thr[r][ch] = s + bnnPkg::accT'($urandom % 17) - bnnPkg::accT'(8);
          endcase
        end
        expBits[r][ch] = (s >= thr[r][ch]);  // Equal sum gives a 1
      end
    end
  endtask

  task automatic loadWeights();
    for (int ch = 0; ch < Chans; ch++) begin
      for (int a = 0; a < Depth; a++) begin
        wgtWe = 1'b1;
        wgtChannel = bnnPkg::chanT'(ch);
        wgtAddr = bnnPkg::addrT'(a);
        wgtData = weights[ch][a];
        @(posedge clk);
        #1;
      end
    end
    wgtWe = 1'b0;
  endtask

  task automatic loadThresholds(input int r);
    for (int ch = 0; ch < Chans; ch++) begin
      thrWe = 1'b1;
      thrChannel = bnnPkg::chanT'(ch);
      thrData = thr[r][ch];
      @(posedge clk);
      #1;
    end
    thrWe = 1'b0;
  endtask

  // Accumulated channel sums must really sit on the threshold boundary
  task automatic checkBoundary(input int r);
    if (!rows[r].copyPrev && rows[r].mode == thrEqual) begin
      for (int ch = 0; ch < Chans; ch++) begin
        checkSum("accSums", dut_i.coreGroup_i.coreSums[ch], thr[r][ch]);
      end
    end
    if (!rows[r].copyPrev && rows[r].mode == thrAbove) begin
      for (int ch = 0; ch < Chans; ch++) begin
        checkSum("accSums", dut_i.coreGroup_i.coreSums[ch], thr[r][ch] - 1'b1);
      end
    end
  endtask

  task automatic sendWords(input int r);
    int n;
    int lat;
    n = rows[r].words;
    for (int i = 0; i < n; i++) begin
      actValid = 1'b1;
      actWord = words[r][i];
      numWords = (i == 0) ? bnnPkg::addrT'(n - 1) : bnnPkg::addrT'($urandom);  // Ignored later
      @(negedge clk);
      checkFlag("actReady", actReady, 1'b1);
      @(posedge clk);
      #1;
      actValid = 1'b0;
      actWord = {$urandom, $urandom};
      if (i < n - 1) repeat (rows[r].gap) begin
        @(posedge clk);
        #1;
      end
    end
    // Count edges from the last accepted word to resValid
    lat = 0;
    @(negedge clk);
    while (!resValid) begin
      checkFlag("actReady", actReady, 1'b0);
      @(posedge clk);
      lat++;
      @(negedge clk);
    end
    checkLatency(lat, ResLatency);
  endtask

  task automatic takeResult(input int r);
    bnnPkg::chanVecT held;
    held = resBits;
    checkBits("resBits", resBits, expBits[r]);
    repeat (rows[r].stall) begin
      @(posedge clk);
      @(negedge clk);
      checkFlag("resValid", resValid, 1'b1);
      checkFlag("actReady", actReady, 1'b0);
      checkBits("resBits", resBits, held);
    end
    if (!resReady) begin
      @(posedge clk);
      #1;
      resReady = 1'b1;
      @(negedge clk);
      checkBits("resBits", resBits, held);
    end
    @(posedge clk);  // Result transfers here
    #1;
    resReady = 1'b0;
    @(negedge clk);
    checkFlag("resValid", resValid, 1'b0);
    checkFlag("actReady", actReady, 1'b1);
    @(posedge clk);
    #1;
  endtask

  initial begin
    seed = 32'hd491_d95d;
    void'($urandom(seed));
    rows[0] = '{5'd1, 4'd0, 4'd0, thrRandom, 1'b0};
    rows[1] = '{5'd16, 4'd0, 4'd0, thrRandom, 1'b0};
    rows[2] = '{5'd5, 4'd0, 4'd0, thrEqual, 1'b0};
    rows[3] = '{5'd5, 4'd0, 4'd0, thrAbove, 1'b0};
    rows[4] = '{5'd7, 4'd0, 4'd0, thrRandom, 1'b0};
    rows[5] = '{5'd7, 4'd3, 4'd0, thrRandom, 1'b1};  // Row 4 again with gaps
    rows[6] = '{5'd3, 4'd1, 4'd6, thrBelow, 1'b0};
    rows[7] = '{5'd2, 4'd0, 4'd0, thrRandom, 1'b0};
    rows[8] = '{5'd16, 4'd1, 4'd3, thrEqual, 1'b0};
    buildModel();
    timeoutLimit = 5 + Chans * Depth + 10;  // Reset and weight load
    for (int r = 0; r < NumRows; r++) begin
      timeoutLimit += int'(rows[r].words) * (int'(rows[r].gap) + 1);
      timeoutLimit += int'(rows[r].stall) + 10 + Chans;
    end

    arstN = 1'b0;
    actValid = 1'b0;
    actWord = '0;
    numWords = '0;
    wgtWe = 1'b0;
    wgtChannel = '0;
    wgtAddr = '0;
    wgtData = '0;
    thrWe = 1'b0;
    thrChannel = '0;
    thrData = '0;
    resReady = 1'b0;
    repeat (5) @(posedge clk);
    #1;
    arstN = 1'b1;
    @(negedge clk);
    checkFlag("resValid", resValid, 1'b0);
    checkFlag("actReady", actReady, 1'b1);
    @(posedge clk);
    #1;

    loadWeights();
    for (int r = 0; r < NumRows; r++) begin
      loadThresholds(r);
      resReady = (rows[r].stall == 0);
      sendWords(r);
      checkBoundary(r);
      takeResult(r);
    end
    $display("TESTS PASSED");
    $finish;
  end

endmodule

`default_nettype wire

/* tb/tbClock.sv */
`timescale 1ns/1ps
`default_nettype none

module tbClock (
  output logic clk
);

  localparam realtime HalfPeriod = 50ns;  // 100 ns clock

  initial clk = 1'b0;

  always #(HalfPeriod) clk = ~clk;

endmodule

`default_nettype wire

/* verilog/BinaryCore.sv */
`timescale 1ns/1ps
`default_nettype none

`include "bnn_macros.svh"

module BinaryCore (
  input  logic            clk,
  input  logic            arstN,
  input  bnnPkg::actWordT actWord,
  input  bnnPkg::actWordT weightWord,  // Already one cycle behind actWord
  input  bnnPkg::accOpE   accOp,
  output bnnPkg::accT     accSum
);

  bnnPkg::actWordT actD;
  bnnPkg::accOpE   opD;
  bnnPkg::accOpE   opD2;
  bnnPkg::actWordT xnorBits;
  bnnPkg::popT     popNext;
  bnnPkg::popT     popReg;

  // Stage 1 alignment with the registered weight read
  always_ff @(posedge clk) actD <= actWord;

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      opD  <= bnnPkg::accHold;
      opD2 <= bnnPkg::accHold;
    end else begin
      opD  <= accOp;
      opD2 <= opD;
    end
  end

  // Matching bits count as +1
  assign xnorBits = ~(actD ^ weightWord);

  always_comb begin
    popNext = '0;
    for (int i = 0; i < `BNN_ACT_WIDTH; i++) begin
      popNext = popNext + bnnPkg::popT'(xnorBits[i]);
    end
  end

  always_ff @(posedge clk) popReg <= popNext;  // Stage 2

  // Stage 3 accumulator
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      accSum <= '0;
    end else begin
      case (opD2)
        bnnPkg::accLoad: accSum <= bnnPkg::accT'(popReg);
        bnnPkg::accAdd:  accSum <= accSum + bnnPkg::accT'(popReg);
        default:         accSum <= accSum;
      endcase
    end
  end

endmodule

`default_nettype wire

/* verilog/BnnLayerTop.sv */
`timescale 1ns/1ps
`default_nettype none

module BnnLayerTop (
  input  logic            clk,
  input  logic            arstN,
  // Activation stream
  input  logic            actValid,
  output logic            actReady,
  input  bnnPkg::actWordT actWord,
  input  bnnPkg::addrT    numWords,     // Word count minus one
  // Weight load
  input  logic            wgtWe,
  input  bnnPkg::chanT    wgtChannel,
  input  bnnPkg::addrT    wgtAddr,
  input  bnnPkg::actWordT wgtData,
  // Threshold load
  input  logic            thrWe,
  input  bnnPkg::chanT    thrChannel,
  input  bnnPkg::accT     thrData,
  // Result stream
  output logic            resValid,
  input  logic            resReady,
  output bnnPkg::chanVecT resBits
);

  coreCtrlIf ctrlIf ();

  LayerSequencer sequencer_i (
    .clk     (clk),
    .arstN   (arstN),
    .actValid(actValid),
    .actReady(actReady),
    .actWord (actWord),
    .numWords(numWords),
    .resValid(resValid),
    .resReady(resReady),
    .ctrl    (ctrlIf.seq)
  );

  ComputeCoreGroup coreGroup_i (
    .clk       (clk),
    .arstN     (arstN),
    .wgtWe     (wgtWe),
    .wgtChannel(wgtChannel),
    .wgtAddr   (wgtAddr),
    .wgtData   (wgtData),
    .ctrl      (ctrlIf.core)
  );

  ThresholdUnit threshold_i (
    .clk       (clk),
    .arstN     (arstN),
    .thrWe     (thrWe),
    .thrChannel(thrChannel),
    .thrData   (thrData),
    .accSums   (ctrlIf.accSums),
    .resBits   (resBits)
  );

endmodule

`default_nettype wire

/* verilog/ComputeCoreGroup.sv */
`timescale 1ns/1ps
`default_nettype none

`include "bnn_macros.svh"

module ComputeCoreGroup (
  input  logic            clk,
  input  logic            arstN,
  input  logic            wgtWe,
  input  bnnPkg::chanT    wgtChannel,
  input  bnnPkg::addrT    wgtAddr,
  input  bnnPkg::actWordT wgtData,
  coreCtrlIf.core         ctrl
);

  bnnPkg::actWordT weightWords [`BNN_CHANNELS];
  bnnPkg::accVecT  coreSums;

  WeightStore weightStore_i (
    .clk       (clk),
    .wgtWe     (wgtWe),
    .wgtChannel(wgtChannel),
    .wgtAddr   (wgtAddr),
    .wgtData   (wgtData),
    .readAddr  (ctrl.weightAddr),
    .readWords (weightWords)
  );

  // Same activation to every channel, own weight per channel
  for (genvar g = 0; g < `BNN_CHANNELS; g++) begin : genCore
    BinaryCore core_i (
      .clk       (clk),
      .arstN     (arstN),
      .actWord   (ctrl.actWord),
      .weightWord(weightWords[g]),
      .accOp     (ctrl.accOp),
      .accSum    (coreSums[g])
    );
  end

  assign ctrl.accSums = coreSums;

endmodule

`default_nettype wire

/* verilog/LayerSequencer.sv */
`timescale 1ns/1ps
`default_nettype none

`include "bnn_macros.svh"

module LayerSequencer (
  input  logic            clk,
  input  logic            arstN,
  input  logic            actValid,
  output logic            actReady,
  input  bnnPkg::actWordT actWord,
  input  bnnPkg::addrT    numWords,
  output logic            resValid,
  input  logic            resReady,
  coreCtrlIf.seq          ctrl
);

  // Drain covers the core pipeline plus the compare register
  localparam int CntW = $clog2(`BNN_PIPE_DEPTH + 1);
  localparam logic [CntW-1:0] DrainLast = CntW'(`BNN_PIPE_DEPTH);

  bnnPkg::seqStateE state;
  bnnPkg::addrT     wordIdx;
  bnnPkg::addrT     lastIdx;   // numWords as sampled with the first word
  bnnPkg::addrT     curLast;
  logic [CntW-1:0]  drainCnt;
  logic             actFire;
  logic             isFirst;
  logic             isLast;

  assign actReady = (state == bnnPkg::seqAccept);
  assign resValid = (state == bnnPkg::seqResult);
  assign actFire  = actValid && actReady;

  assign isFirst = (wordIdx == '0);
  assign curLast = isFirst ? numWords : lastIdx;  // Count not yet registered on word 0
  assign isLast  = (wordIdx == curLast);

  assign ctrl.actWord    = actWord;
  assign ctrl.weightAddr = wordIdx;
  assign ctrl.accOp      = !actFire ? bnnPkg::accHold :
                           (isFirst ? bnnPkg::accLoad : bnnPkg::accAdd);

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      state    <= bnnPkg::seqAccept;
      wordIdx  <= '0;
      lastIdx  <= '0;
      drainCnt <= '0;
    end else begin
      case (state)
        bnnPkg::seqAccept: begin
          if (actFire) begin
            if (isFirst) lastIdx <= numWords;
            if (isLast) begin
              wordIdx  <= '0;
              drainCnt <= '0;
              state    <= bnnPkg::seqDrain;
            end else begin
              wordIdx <= wordIdx + bnnPkg::addrT'(1);
            end
          end
        end
        bnnPkg::seqDrain: begin
          if (drainCnt == DrainLast) state <= bnnPkg::seqResult;
          else drainCnt <= drainCnt + 1'b1;
        end
        bnnPkg::seqResult: begin
          // Hold until the result is taken
          if (resReady) state <= bnnPkg::seqAccept;
        end
        default: state <= bnnPkg::seqAccept;
      endcase
    end
  end

endmodule

`default_nettype wire

/* verilog/ThresholdUnit.sv */
`timescale 1ns/1ps
`default_nettype none

`include "bnn_macros.svh"

module ThresholdUnit (
  input  logic             clk,
  input  logic             arstN,
  input  logic             thrWe,
  input  bnnPkg::chanT     thrChannel,
  input  bnnPkg::accT      thrData,
  input  bnnPkg::accVecT   accSums,
  output bnnPkg::chanVecT  resBits
);

  bnnPkg::accT thresholds [`BNN_CHANNELS];

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      for (int ch = 0; ch < `BNN_CHANNELS; ch++) begin
        thresholds[ch] <= '0;
      end
    end else if (thrWe) begin
      thresholds[thrChannel] <= thrData;
    end
  end

  // Batch-norm style sign decision, one bit per channel
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      resBits <= '0;
    end else begin
      for (int ch = 0; ch < `BNN_CHANNELS; ch++) begin
        resBits[ch] <= (accSums[ch] >= thresholds[ch]);  // Equal counts as 1
      end
    end
  end

endmodule

`default_nettype wire

/* verilog/WeightStore.sv */
`timescale 1ns/1ps
`default_nettype none

`include "bnn_macros.svh"

module WeightStore (
  input  logic            clk,
  input  logic            wgtWe,
  input  bnnPkg::chanT    wgtChannel,
  input  bnnPkg::addrT    wgtAddr,
  input  bnnPkg::actWordT wgtData,
  input  bnnPkg::addrT    readAddr,
  output bnnPkg::actWordT readWords [`BNN_CHANNELS]
);

  // One weight word per channel and word position
  bnnPkg::actWordT mem [`BNN_CHANNELS][`BNN_WEIGHT_DEPTH];

  // Host write port
  always_ff @(posedge clk) begin
    if (wgtWe) mem[wgtChannel][wgtAddr] <= wgtData;
  end

  // All channels read at the same index
  always_ff @(posedge clk) begin
    for (int ch = 0; ch < `BNN_CHANNELS; ch++) begin
      readWords[ch] <= mem[ch][readAddr];  // Pipeline stage 1
    end
  end

endmodule

`default_nettype wire

/* verilog/bnnPkg.sv */
`default_nettype none

`include "bnn_macros.svh"

package bnnPkg;

  typedef logic [`BNN_ACT_WIDTH-1:0] actWordT;
  typedef logic [`BNN_ADDR_WIDTH-1:0] addrT;
  typedef logic [`BNN_POP_WIDTH-1:0] popT;
  typedef logic [`BNN_ACC_WIDTH-1:0] accT;
  typedef logic [$clog2(`BNN_CHANNELS)-1:0] chanT;
  typedef logic [`BNN_CHANNELS-1:0] chanVecT;
  typedef accT [`BNN_CHANNELS-1:0] accVecT;

  // Accumulator opcode that travels with each word
  typedef enum logic [1:0] {
    accHold,
    accLoad,
    accAdd
  } accOpE;

  typedef enum logic [1:0] {
    seqAccept,
    seqDrain,
    seqResult
  } seqStateE;

endpackage

`default_nettype wire

/* verilog/coreCtrlIf.sv */
`timescale 1ns/1ps
`default_nettype none

interface coreCtrlIf;

  bnnPkg::actWordT actWord;     // Word accepted this cycle
  bnnPkg::addrT    weightAddr;  // Its position in the result
  bnnPkg::accOpE   accOp;       // accHold when nothing accepted
  bnnPkg::accVecT  accSums;

  modport seq (
    output actWord,
    output weightAddr,
    output accOp
  );

  modport core (
    input  actWord,
    input  weightAddr,
    input  accOp,
    output accSums
  );

endinterface

`default_nettype wire
